/* flist.f */
+incdir+include
design/cache_pkg.sv
design/packet_queue.sv
design/priority_arbiter.sv
design/return_router.sv
design/unified_cache_front.sv
verif/tb_unified_cache_front.sv

/* run.sh */
#!/bin/sh
# Builds the testbench with Verilator and runs it once.
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -f flist.f --top-module tb_unified_cache_front -o sim_tb

output=$(./obj_dir/sim_tb)
echo "$output"

if echo "$output" | grep -q "^Regression passed$"; then
    exit 0
fi
exit 1

/* verif/tb_unified_cache_front.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_defs.svh"

module tb_unified_cache_front;

    typedef struct packed {
        logic [`PORT_ID_WIDTH-1:0]  port;
        logic                       is_write;
        logic [`ADDR_WIDTH-1:0]     addr;
        logic [`DATA_WIDTH-1:0]     data;
        int                         order;      // Position on to_mem, or -1 if free.
        int                         group;
    } stim_row_t;

    localparam int NUM_ROWS    = 23;
    localparam int WATCHDOG_NS = NUM_ROWS * 200 + 5000;

    logic                               clk_in = 1'b0;
    logic                               reset;
    cache_pkg::cache_request_t          request [`NUM_INPUT_PORT];
    logic [`NUM_INPUT_PORT-1:0]         request_valid;
    logic [`NUM_INPUT_PORT-1:0]         request_ack;
    cache_pkg::cache_request_t          to_mem;
    logic                               to_mem_valid;
    logic                               to_mem_ack;
    cache_pkg::mem_response_t           from_mem;
    logic                               from_mem_valid;
    logic                               from_mem_ack;
    cache_pkg::mem_response_t           response [`NUM_INPUT_PORT];
    logic [`NUM_INPUT_PORT-1:0]         response_valid;
    logic [`NUM_INPUT_PORT-1:0]         response_ack;

    stim_row_t                  stim_table [NUM_ROWS];
    int                         drive_row [`NUM_INPUT_PORT];
    int                         req_rows [`NUM_INPUT_PORT][$];   // Accepted, not yet on to_mem.
    int                         resp_rows [`NUM_INPUT_PORT][$];  // Accepted, response not yet back.
    int                         ret_count [`NUM_INPUT_PORT];     // Replies held in the return queue.
    cache_pkg::mem_response_t   mem_queue [$];
    int                         mem_seen = 0;
    int                         request_errors = 0;
    int                         response_errors = 0;
    int                         protocol_errors = 0;
    logic                       mem_hold = 1'b0;
    logic                       mem_random = 1'b0;
    logic                       resp_random = 1'b0;

    unified_cache_front uut
    (
        .clk_in         (clk_in),
        .reset          (reset),
        .request        (request),
        .request_valid  (request_valid),
        .request_ack    (request_ack),
        .to_mem         (to_mem),
        .to_mem_valid   (to_mem_valid),
        .to_mem_ack     (to_mem_ack),
        .from_mem       (from_mem),
        .from_mem_valid (from_mem_valid),
        .from_mem_ack   (from_mem_ack),
        .response       (response),
        .response_valid (response_valid),
        .response_ack   (response_ack)
    );

    always #5 clk_in = ~clk_in;

    task automatic load_table();
        stim_table[0]  = '{1'b0, 1'b0, 32'h0000_1000, 32'h1234_5678, 0, 0};
        stim_table[1]  = '{1'b0, 1'b1, 32'h0000_2000, 32'ha5a5_0001, 1, 1};
        stim_table[2]  = '{1'b1, 1'b0, 32'h0000_2004, 32'h5a5a_0002, 2, 1};
        stim_table[3]  = '{1'b0, 1'b0, 32'h0000_3000, 32'hdead_0000, 3, 2};
        stim_table[4]  = '{1'b0, 1'b1, 32'h0000_3100, 32'h0f0f_0100, 5, 3};
        stim_table[5]  = '{1'b0, 1'b0, 32'h0000_3104, 32'h0f0f_0104, 6, 3};
        stim_table[6]  = '{1'b0, 1'b1, 32'h0000_3108, 32'h0f0f_0108, 7, 3};
        stim_table[7]  = '{1'b1, 1'b0, 32'h0000_3200, 32'hf0f0_0200, 4, 3};
        stim_table[8]  = '{1'b1, 1'b1, 32'h0000_3204, 32'hf0f0_0204, 8, 3};
        stim_table[9]  = '{1'b1, 1'b0, 32'h0000_3208, 32'hf0f0_0208, 9, 3};
        stim_table[10] = '{1'b1, 1'b1, 32'h0000_320c, 32'hf0f0_020c, 10, 3};
        stim_table[11] = '{1'b0, 1'b0, 32'h0000_4000, 32'h1111_4000, -1, 4};
        stim_table[12] = '{1'b0, 1'b1, 32'h0000_4004, 32'h2222_4004, -1, 4};
        stim_table[13] = '{1'b0, 1'b0, 32'h0000_4008, 32'h3333_4008, -1, 4};
        stim_table[14] = '{1'b1, 1'b1, 32'h0000_4100, 32'h4444_4100, -1, 4};
        stim_table[15] = '{1'b1, 1'b0, 32'h0000_4104, 32'h5555_4104, -1, 4};
        stim_table[16] = '{1'b1, 1'b1, 32'h0000_4108, 32'h6666_4108, -1, 4};
        stim_table[17] = '{1'b0, 1'b0, 32'h0000_5000, 32'h7777_5000, -1, 5};
        stim_table[18] = '{1'b0, 1'b1, 32'h0000_5004, 32'h8888_5004, -1, 5};
        stim_table[19] = '{1'b0, 1'b0, 32'h0000_5008, 32'h9999_5008, -1, 5};
        stim_table[20] = '{1'b1, 1'b1, 32'h0000_5100, 32'haaaa_5100, -1, 5};
        stim_table[21] = '{1'b1, 1'b0, 32'h0000_5104, 32'hbbbb_5104, -1, 5};
        stim_table[22] = '{1'b1, 1'b1, 32'h0000_5108, 32'hcccc_5108, -1, 5};
    endtask

    function automatic cache_pkg::cache_request_t expected_request(input int row);
        cache_pkg::cache_request_t req;
        req.port_id  = stim_table[row].port;
        req.is_write = stim_table[row].is_write;
        req.addr     = stim_table[row].addr;
        req.data     = stim_table[row].data;
        return req;
    endfunction

    function automatic cache_pkg::mem_response_t expected_response(input int row);
        cache_pkg::mem_response_t resp;
        resp.port_id = stim_table[row].port;
        resp.addr    = stim_table[row].addr;
        resp.data    = ~stim_table[row].data;       // Memory answers with the inverted data.
        return resp;
    endfunction

    task automatic check_request(input cache_pkg::cache_request_t expected,
                                 input cache_pkg::cache_request_t actual);
        if (actual !== expected)
        begin
            request_errors++;
            $display("[FAIL] %0t ns: to_mem sent %h, expected %h", $time, actual, expected);
        end
    endtask

    task automatic check_response(input cache_pkg::mem_response_t expected,
                                  input cache_pkg::mem_response_t actual);
        if (actual !== expected)
        begin
            response_errors++;
            $display("[FAIL] %0t ns: response %h, expected %h", $time, actual, expected);
        end
    endtask

    task automatic report_problem(input string text);
        protocol_errors++;
        $display("At %0t ns: %s", $time, text);
    endtask

    task automatic send_row(input int row);
        int port;
        port = int'(stim_table[row].port);
        request[port]       = expected_request(row);
        drive_row[port]     = row;
        request_valid[port] = 1'b1;
        do
            @(posedge clk_in);
        while (!request_ack[port]);
        #1;
        request_valid[port] = 1'b0;
    endtask

    task automatic send_port_rows(input int port, input int group);
        for (int row = 0; row < NUM_ROWS; row++)
            if (stim_table[row].group == group && int'(stim_table[row].port) == port)
                send_row(row);
    endtask

    task automatic run_group(input int group);
        fork
            send_port_rows(0, group);
            send_port_rows(1, group);
        join
    endtask

    function automatic int outstanding();
        int total;
        total = 0;
        for (int p = 0; p < `NUM_INPUT_PORT; p++)
            total += req_rows[p].size() + resp_rows[p].size();
        return total;
    endfunction

    task automatic wait_drained();
        while (outstanding() != 0)
        begin
            @(posedge clk_in);
            #1;
        end
    endtask

    // Scoreboard and memory model, all sampled at the rising edge.
    always @(posedge clk_in)
    begin : monitor
        cache_pkg::mem_response_t reply;
        int row;
        int port;
        if (!reset)
        begin
            if (from_mem_valid)
            begin
                port = int'(from_mem.port_id);
                if (from_mem_ack !== (ret_count[port] < `RETURN_QUEUE_SIZE))
                begin
                    response_errors++;
                    $display("[FAIL] %0t ns: from_mem_ack %b with %0d replies held on port %0d",
                             $time, from_mem_ack, ret_count[port], port);
                end
                if (from_mem_ack)
                begin
                    ret_count[port]++;
                    void'(mem_queue.pop_front());
                end
            end
            for (int p = 0; p < `NUM_INPUT_PORT; p++)
            begin
                if (!request_ack[p] && req_rows[p].size() < `INPUT_QUEUE_SIZE)
                    report_problem($sformatf("port %0d refused a request with only %0d waiting",
                                             p, req_rows[p].size()));
                if (request_ack[p] && req_rows[p].size() > `INPUT_QUEUE_SIZE)
                    report_problem($sformatf("port %0d took a request past its queue depth", p));
                if (response_valid[p] && response_ack[p])
                begin
                    ret_count[p]--;
                    if (resp_rows[p].size() == 0)
                        report_problem($sformatf("port %0d returned an unrequested response", p));
                    else
                    begin
                        row = resp_rows[p].pop_front();
                        check_response(expected_response(row), response[p]);
                    end
                end
            end
            if (to_mem_valid && to_mem_ack)
            begin
                port = int'(to_mem.port_id);
                if (req_rows[port].size() == 0)
                    report_problem($sformatf("to_mem sent a packet for port %0d that was not sent",
                                             port));
                else
                begin
                    row = req_rows[port].pop_front();
                    check_request(expected_request(row), to_mem);
                    if (stim_table[row].order >= 0 && stim_table[row].order != mem_seen)
                    begin
                        request_errors++;
                        $display("[FAIL] %0t ns: row %0d reached to_mem at position %0d, expected %0d",
                                 $time, row, mem_seen, stim_table[row].order);
                    end
                end
                mem_seen++;
                reply.port_id = to_mem.port_id;
                reply.addr    = to_mem.addr;
                reply.data    = ~to_mem.data;
                mem_queue.push_back(reply);
            end
            for (int p = 0; p < `NUM_INPUT_PORT; p++)
            begin
                if (request_valid[p] && request_ack[p])
                begin
                    req_rows[p].push_back(drive_row[p]);
                    resp_rows[p].push_back(drive_row[p]);
                end
            end
        end
    end

    initial
    begin : memory_side
        to_mem_ack     = 1'b1;
        response_ack   = '1;
        from_mem       = '0;
        from_mem_valid = 1'b0;
        forever
        begin
            @(posedge clk_in);
            #1;
            to_mem_ack = mem_random ? (($urandom % 2) == 0) : !mem_hold;
            for (int p = 0; p < `NUM_INPUT_PORT; p++)
                response_ack[p] = resp_random ? (($urandom % 2) == 0) : 1'b1;
            from_mem_valid = (mem_queue.size() != 0);
            if (from_mem_valid)
                from_mem = mem_queue[0];
        end
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("Timeout: the run did not finish within %0d ns.", WATCHDOG_NS);
        $display("Regression failed");
        $finish;
    end

    initial
    begin
        void'($urandom(32'h43f2_5c66));
        load_table();
        reset         = 1'b1;
        request_valid = '0;
        for (int p = 0; p < `NUM_INPUT_PORT; p++)
        begin
            request[p]   = '0;
            drive_row[p] = 0;
            ret_count[p] = 0;
        end
        repeat (10) @(posedge clk_in);
        #1;
        reset = 1'b0;
        run_group(0);
        wait_drained();
        run_group(1);                               // Both ports in the same cycle.
        wait_drained();
        mem_hold = 1'b1;
        run_group(2);
        while (!to_mem_valid)
        begin
            @(posedge clk_in);
            #1;
        end
        run_group(3);                               // Port 1 queue ends up full.
        mem_hold = 1'b0;
        wait_drained();
        mem_random = 1'b1;
        run_group(4);
        wait_drained();
        mem_random  = 1'b0;
        resp_random = 1'b1;
        run_group(5);
        wait_drained();
        if (mem_seen != NUM_ROWS)
            report_problem($sformatf("%0d packets reached to_mem for %0d rows", mem_seen, NUM_ROWS));
        $display("Errors: request %0d, response %0d, protocol %0d",
                 request_errors, response_errors, protocol_errors);
        if (request_errors + response_errors + protocol_errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

`default_nettype wire

/* design/unified_cache_front.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_defs.svh"

module unified_cache_front
(
    input  logic                            clk_in,
    input  logic                            reset,

    input  cache_pkg::cache_request_t       request [`NUM_INPUT_PORT],
    input  logic [`NUM_INPUT_PORT-1:0]      request_valid,
    output logic [`NUM_INPUT_PORT-1:0]      request_ack,

    output cache_pkg::cache_request_t       to_mem,
    output logic                            to_mem_valid,
    input  logic                            to_mem_ack,

    input  cache_pkg::mem_response_t        from_mem,
    input  logic                            from_mem_valid,
    output logic                            from_mem_ack,

    output cache_pkg::mem_response_t        response [`NUM_INPUT_PORT],
    output logic [`NUM_INPUT_PORT-1:0]      response_valid,
    input  logic [`NUM_INPUT_PORT-1:0]      response_ack
);

    cache_pkg::cache_request_t  queue_head [`NUM_INPUT_PORT];
    logic [`NUM_INPUT_PORT-1:0] queue_head_valid;
    logic [`NUM_INPUT_PORT-1:0] queue_full;
    logic [`NUM_INPUT_PORT-1:0] arbiter_ack;

    for (genvar gen = 0; gen < `NUM_INPUT_PORT; gen++)
    begin : input_port_gen
        packet_queue
        #(
            .payload_t  (cache_pkg::cache_request_t),
            .DEPTH      (`INPUT_QUEUE_SIZE)
        )
        input_queue
        (
            .clk_in     (clk_in),
            .reset      (reset),
            .push_data  (request[gen]),
            .push_valid (request_valid[gen]),
            .push_ack   (request_ack[gen]),
            .pop_data   (queue_head[gen]),
            .pop_valid  (queue_head_valid[gen]),
            .pop_ack    (arbiter_ack[gen]),
            .full       (queue_full[gen])           // A full queue jumps the fixed order.
        );
    end

    priority_arbiter
    #(
        .NUM_REQUESTS       (`NUM_INPUT_PORT)
    )
    input_arbiter
    (
        .clk_in             (clk_in),
        .reset              (reset),
        .request            (queue_head),
        .request_valid      (queue_head_valid),
        .request_critical   (queue_full),
        .request_ack        (arbiter_ack),
        .grant              (to_mem),
        .grant_valid        (to_mem_valid),
        .grant_ack          (to_mem_ack)
    );

    return_router return_path
    (
        .clk_in             (clk_in),
        .reset              (reset),
        .from_mem           (from_mem),
        .from_mem_valid     (from_mem_valid),
        .from_mem_ack       (from_mem_ack),
        .response           (response),
        .response_valid     (response_valid),
        .response_ack       (response_ack)
    );

endmodule

`default_nettype wire

/* design/return_router.sv */
`timescale 1ns/1ps
`default_nettype none

`include "cache_defs.svh"

module return_router
(
    input  logic                            clk_in,
    input  logic                            reset,

    input  cache_pkg::mem_response_t        from_mem,
    input  logic                            from_mem_valid,
    output logic                            from_mem_ack,

    output cache_pkg::mem_response_t        response [`NUM_INPUT_PORT],
    output logic [`NUM_INPUT_PORT-1:0]      response_valid,
    input  logic [`NUM_INPUT_PORT-1:0]      response_ack
);

    logic [`NUM_INPUT_PORT-1:0] port_push_valid;
    logic [`NUM_INPUT_PORT-1:0] port_push_ack;
    logic                       port_in_range;

    assign port_in_range = (int'(from_mem.port_id) < `NUM_INPUT_PORT);

    // Only the addressed queue decides whether memory may hand over the reply.
    assign from_mem_ack = port_in_range && port_push_ack[from_mem.port_id];

    for (genvar gen = 0; gen < `NUM_INPUT_PORT; gen++)
    begin : return_port_gen
        assign port_push_valid[gen] = from_mem_valid && (int'(from_mem.port_id) == gen);

        packet_queue
        #(
            .payload_t  (cache_pkg::mem_response_t),
            .DEPTH      (`RETURN_QUEUE_SIZE)
        )
        return_queue
        (
            .clk_in     (clk_in),
            .reset      (reset),
            .push_data  (from_mem),
            .push_valid (port_push_valid[gen]),
            .push_ack   (port_push_ack[gen]),
            .pop_data   (response[gen]),
            .pop_valid  (response_valid[gen]),
            .pop_ack    (response_ack[gen]),
            .full       ()                          // Back-pressure already shows on push_ack.
        );
    end

    port_id_in_range: assert property (@(posedge clk_in) disable iff (reset)
        from_mem_valid |-> port_in_range);

endmodule

`default_nettype wire

/* design/priority_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module priority_arbiter
#(
    parameter int NUM_REQUESTS = 2
)
(
    input  logic                        clk_in,
    input  logic                        reset,

    // Index 0 has the highest priority.
    input  cache_pkg::cache_request_t   request [NUM_REQUESTS],
    input  logic [NUM_REQUESTS-1:0]     request_valid,
    input  logic [NUM_REQUESTS-1:0]     request_critical,
    output logic [NUM_REQUESTS-1:0]     request_ack,

    output cache_pkg::cache_request_t   grant,
    output logic                        grant_valid,
    input  logic                        grant_ack
);

    localparam int INDEX_WIDTH = (NUM_REQUESTS > 1) ? $clog2(NUM_REQUESTS) : 1;

    logic [NUM_REQUESTS-1:0]    select_onehot;
    logic [INDEX_WIDTH-1:0]     select_index;
    logic                       found;
    logic                       load;

    // Critical requests (full queues) are scanned first, then the plain valid ones.
    always_comb
    begin
        select_onehot = '0;
        select_index  = '0;
        found         = 1'b0;
        for (int i = 0; i < NUM_REQUESTS; i++)
        begin
            if (!found && request_valid[i] && request_critical[i])
            begin
                select_onehot[i] = 1'b1;
                select_index     = INDEX_WIDTH'(i);
                found            = 1'b1;
            end
        end
        for (int i = 0; i < NUM_REQUESTS; i++)
        begin
            if (!found && request_valid[i])
            begin
                select_onehot[i] = 1'b1;
                select_index     = INDEX_WIDTH'(i);
                found            = 1'b1;
            end
        end
    end

    assign load        = !grant_valid || grant_ack;    // Output register free at next edge.
    assign request_ack = load ? select_onehot : '0;

    always_ff @(posedge clk_in)
    begin
        if (reset)
            grant_valid <= 1'b0;
        else if (load)
            grant_valid <= found;
    end

    always_ff @(posedge clk_in)
    begin
        if (load && found)
            grant <= request[select_index];
    end

    request_ack_onehot: assert property (@(posedge clk_in) disable iff (reset)
        $onehot0(request_ack));

    // The memory side sees a stable packet until it takes it.
    grant_stable: assert property (@(posedge clk_in) disable iff (reset)
        grant_valid && !grant_ack |=> grant_valid && $stable(grant));

endmodule

`default_nettype wire

/* design/packet_queue.sv */
`timescale 1ns/1ps
`default_nettype none

module packet_queue
#(
    parameter type payload_t = logic [7:0],
    parameter int  DEPTH     = 4
)
(
    input  logic        clk_in,
    input  logic        reset,

    input  payload_t    push_data,
    input  logic        push_valid,
    output logic        push_ack,

    output payload_t    pop_data,
    output logic        pop_valid,
    input  logic        pop_ack,

    output logic        full
);

    localparam int PTR_WIDTH   = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int COUNT_WIDTH = $clog2(DEPTH + 1);

    payload_t               entries [DEPTH];
    logic [PTR_WIDTH-1:0]   write_ptr;
    logic [PTR_WIDTH-1:0]   read_ptr;
    logic [COUNT_WIDTH-1:0] count;
    logic                   do_push;
    logic                   do_pop;

    assign full      = (count == COUNT_WIDTH'(DEPTH));
    assign push_ack  = !full;                           // Does not look at push_valid.
    assign pop_valid = (count != '0);
    assign pop_data  = entries[read_ptr];
    assign do_push   = push_valid && push_ack;
    assign do_pop    = pop_valid && pop_ack;

    always_ff @(posedge clk_in)
    begin
        if (do_push)
            entries[write_ptr] <= push_data;
    end

    always_ff @(posedge clk_in)
    begin
        if (reset)
        begin
            write_ptr <= '0;
            read_ptr  <= '0;
            count     <= '0;
        end
        else
        begin
            if (do_push)
                write_ptr <= (write_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : write_ptr + 1'b1;
            if (do_pop)
                read_ptr <= (read_ptr == PTR_WIDTH'(DEPTH - 1)) ? '0 : read_ptr + 1'b1;
            case ({do_push, do_pop})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;                // Push and pop together leave it.
            endcase
        end
    end

    // A full queue has its write pointer wrapped round onto the read pointer.
    full_pointers_meet: assert property (@(posedge clk_in) disable iff (reset)
        full |-> (write_ptr == read_ptr));

    // An empty queue has both pointers on the same slot.
    empty_pointers_meet: assert property (@(posedge clk_in) disable iff (reset)
        !pop_valid |-> (write_ptr == read_ptr));

endmodule

`default_nettype wire

/* design/cache_pkg.sv */
`default_nettype none

`include "cache_defs.svh"

package cache_pkg;

    // One client request as it travels from the input queue to memory.
    typedef struct packed {
        logic [`PORT_ID_WIDTH-1:0]  port_id;    // Client port that issued it.
        logic                       is_write;
        logic [`ADDR_WIDTH-1:0]     addr;
        logic [`DATA_WIDTH-1:0]     data;
    } cache_request_t;

    // One memory reply, steered back by port_id.
    typedef struct packed {
        logic [`PORT_ID_WIDTH-1:0]  port_id;
        logic [`ADDR_WIDTH-1:0]     addr;
        logic [`DATA_WIDTH-1:0]     data;
    } mem_response_t;

endpackage

`default_nettype wire

/* include/cache_defs.svh */
`ifndef CACHE_DEFS_SVH
`define CACHE_DEFS_SVH

// Client side of the front end.
`define NUM_INPUT_PORT      2
`define INPUT_QUEUE_SIZE    4

// Per-port return path.
`define RETURN_QUEUE_SIZE   2

// Packet field widths.
`define ADDR_WIDTH          32
`define DATA_WIDTH          32
`define PORT_ID_WIDTH       1

`endif
